/* blitter.f */
source/blit_pkg.sv
source/blit_regs.sv
source/blit_sequencer.sv
source/blit_datapath.sv
source/blitter_top.sv
verification/vram_model.sv
verification/tb_blitter.sv

/* run_sim.sh */
#!/bin/sh
# build and run the blitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_blitter -f blitter.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_blitter > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0

/* source/blit_datapath.sv */
module blit_datapath import blit_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       vram_ack_i,
    input  word_t      vram_data_i,
    input  logic       load_a_i,
    input  logic       init_a_i,
    input  logic [1:0] shift_amount_i,
    input  logic       b_not_i,
    input  word_t      val_b_i,
    input  word_t      val_c_i,
    input  word_t      src_a_i,
    output word_t      data_o
);

    word_t val_a;
    word_t last_a;                      // previous raw A word
    word_t b_prime;

    // right shift by whole nibbles, low nibbles of prev fill the top
    function automatic word_t shift_right(input logic [1:0] amount, input word_t data,
                                          input word_t prev);
        case (amount)
            2'd0:    return data;
            2'd1:    return {prev[3:0], data[15:4]};
            2'd2:    return {prev[7:0], data[15:8]};
            default: return {prev[11:0], data[15:12]};
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            last_a <= '0;
        end else if (load_a_i && vram_ack_i) begin
            last_a <= vram_data_i;      // carried across lines and blits
        end
    end

    always_ff @(posedge clk) begin
        if (init_a_i) begin
            val_a <= src_a_i;           // constant A, replaced by reads otherwise
        end else if (load_a_i && vram_ack_i) begin
            val_a <= shift_right(shift_amount_i, vram_data_i, last_a);
        end
    end

    assign b_prime = b_not_i ? ~val_b_i : val_b_i;
    assign data_o  = (val_a & b_prime) ^ val_c_i;   // D = A AND B' XOR C

endmodule

/* source/blit_pkg.sv */
package blit_pkg;

    typedef logic [15:0] word_t;        // one VRAM data word
    typedef logic [3:0]  nib_mask_t;    // bit 3 enables the high nibble

    // host register numbers, anything else is ignored
    typedef enum logic [3:0] {
        BLIT_CTRL  = 4'd0,              // bit 0 a_const, bit 2 b_not
        BLIT_SHIFT = 4'd1,              // [15:12] f_mask, [11:8] l_mask, [1:0] shift
        BLIT_MOD_A = 4'd2,
        BLIT_MOD_D = 4'd3,
        BLIT_SRC_A = 4'd4,
        BLIT_VAL_B = 4'd5,
        BLIT_VAL_C = 4'd6,
        BLIT_DST_D = 4'd7,
        BLIT_LINES = 4'd8,              // line count minus one
        BLIT_WORDS = 4'd9               // word count minus one, queues the blit
    } blit_reg_e;

    typedef enum logic [2:0] {
        IDLE,                           // nothing queued
        SETUP,                          // take the queued descriptor
        LINE_BEG,                       // reload word counter and first mask
        RD_A,                           // source read
        WR_D,                           // destination write
        LINE_END                        // apply modulos, next line or finish
    } blit_state_e;

    typedef struct packed {
        logic      a_const;             // A is src_a as a constant
        logic      b_not;               // use NOT B in the logic op
        logic [1:0] shift_amount;       // right shift in nibbles
        nib_mask_t f_mask;              // first word of each line
        nib_mask_t l_mask;              // last word of each line
        word_t     mod_a;
        word_t     mod_d;
        word_t     src_a;
        word_t     val_b;
        word_t     val_c;
        word_t     dst_d;
        word_t     lines;
        word_t     words;
    } blit_desc_t;

    typedef struct packed {
        logic      sel;                 // held until ack
        logic      wr;
        nib_mask_t wr_mask;
        word_t     addr;
    } vram_req_t;

endpackage

/* source/blit_regs.sv */
module blit_regs import blit_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       reg_wr_i,        // one write per cycle, no handshake
    input  blit_reg_e  reg_num_i,
    input  word_t      reg_data_i,
    input  logic       setup_i,         // sequencer took the descriptor
    output blit_desc_t desc_o,
    output logic       queued_o         // also the full status
);

    blit_desc_t desc_q;
    logic       queued_q;

    assign desc_o   = desc_q;
    assign queued_o = queued_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            desc_q   <= '0;
            queued_q <= 1'b0;
        end else begin
            if (setup_i) begin
                queued_q <= 1'b0;
            end

            // a words write in the setup cycle overrides the clear above
            if (reg_wr_i) begin
                case (reg_num_i)
                    BLIT_CTRL: begin
                        desc_q.b_not   <= reg_data_i[2];
                        desc_q.a_const <= reg_data_i[0];
                    end
                    BLIT_SHIFT: begin
                        desc_q.f_mask       <= reg_data_i[15:12];
                        desc_q.l_mask       <= reg_data_i[11:8];
                        desc_q.shift_amount <= reg_data_i[1:0];
                    end
                    BLIT_MOD_A: desc_q.mod_a <= reg_data_i;
                    BLIT_MOD_D: desc_q.mod_d <= reg_data_i;
                    BLIT_SRC_A: desc_q.src_a <= reg_data_i;
                    BLIT_VAL_B: desc_q.val_b <= reg_data_i;
                    BLIT_VAL_C: desc_q.val_c <= reg_data_i;
                    BLIT_DST_D: desc_q.dst_d <= reg_data_i;
                    BLIT_LINES: desc_q.lines <= reg_data_i;
                    BLIT_WORDS: begin
                        desc_q.words <= reg_data_i;
                        queued_q     <= 1'b1;   // blit is now pending
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // host may only queue when the slot is free or being taken this cycle
    a_no_overrun: assert property (
        @(posedge clk) disable iff (reset_i)
        (reg_wr_i && reg_num_i == BLIT_WORDS) |-> (!queued_q || setup_i)
    ) else $error("blit queued while queue full");

endmodule

/* source/blit_sequencer.sv */
module blit_sequencer import blit_pkg::*; #(
    parameter int ADDR_W = 16
) (
    input  logic       clk,
    input  logic       reset_i,
    input  blit_desc_t desc_i,
    input  logic       queued_i,
    output logic       setup_o,
    input  logic       vram_ack_i,
    output vram_req_t  vram_req_o,
    output logic       load_a_o,        // datapath captures read data on ack
    output logic       init_a_o,        // datapath loads src_a as constant
    output logic [1:0] shift_amount_o,
    output logic       b_not_o,
    output word_t      val_b_o,
    output word_t      val_c_o,
    output logic       busy_o,
    output logic       done_o
);

    blit_state_e       state_q, state_n;
    blit_desc_t        cur_q;                   // working copy of the running blit
    logic              sel_q, sel_n;
    logic              wr_q, wr_n;
    logic [ADDR_W-1:0] addr_q, addr_n;
    logic [ADDR_W-1:0] a_addr_q, a_addr_n;
    logic [ADDR_W-1:0] d_addr_q, d_addr_n;
    word_t             lines_q, lines_n;        // bit 15 set on the last line
    logic [16:0]       count_q, count_n;        // bit 16 set on the last word
    nib_mask_t         fmask_q, fmask_n;
    logic              done_q, done_n;
    logic              advance;

    assign advance = !sel_q || vram_ack_i;      // everything waits on ack

    assign vram_req_o = '{sel: sel_q, wr: wr_q,
                          wr_mask: fmask_q & (count_q[16] ? cur_q.l_mask : 4'hf),
                          addr: word_t'(addr_q)};

    assign shift_amount_o = cur_q.shift_amount;
    assign b_not_o        = cur_q.b_not;
    assign val_b_o        = cur_q.val_b;
    assign val_c_o        = cur_q.val_c;
    assign busy_o         = (state_q != IDLE);
    assign done_o         = done_q;

    always_comb begin
        state_n  = state_q;
        sel_n    = 1'b0;
        wr_n     = 1'b0;
        addr_n   = addr_q;
        a_addr_n = a_addr_q;
        d_addr_n = d_addr_q;
        lines_n  = lines_q;
        count_n  = count_q;
        fmask_n  = fmask_q;
        done_n   = 1'b0;
        setup_o  = 1'b0;
        init_a_o = 1'b0;
        load_a_o = 1'b0;

        case (state_q)
            IDLE: begin
                if (queued_i) begin
                    state_n = SETUP;
                end
            end
            SETUP: begin
                setup_o  = 1'b1;
                init_a_o = 1'b1;
                a_addr_n = desc_i.src_a[ADDR_W-1:0];
                d_addr_n = desc_i.dst_d[ADDR_W-1:0];
                lines_n  = desc_i.lines;
                state_n  = LINE_BEG;
            end
            LINE_BEG: begin
                fmask_n = cur_q.f_mask;
                lines_n = lines_q - 1'b1;               // underflows on the last line
                count_n = {1'b0, cur_q.words} - 1'b1;   // underflows on the last word
                sel_n   = 1'b1;
                if (!cur_q.a_const) begin
                    addr_n  = a_addr_q;
                    state_n = RD_A;
                end else begin
                    wr_n    = 1'b1;
                    addr_n  = d_addr_q;
                    state_n = WR_D;
                end
            end
            RD_A: begin
                load_a_o = 1'b1;
                a_addr_n = a_addr_q + 1'b1;
                sel_n    = 1'b1;
                wr_n     = 1'b1;
                addr_n   = d_addr_q;
                state_n  = WR_D;
            end
            WR_D: begin
                d_addr_n = d_addr_q + 1'b1;
                count_n  = count_q - 1'b1;
                fmask_n  = 4'hf;                        // first word done
                if (count_q[16]) begin
                    state_n = LINE_END;
                end else if (!cur_q.a_const) begin
                    sel_n   = 1'b1;
                    addr_n  = a_addr_q;
                    state_n = RD_A;
                end else begin
                    sel_n   = 1'b1;
                    wr_n    = 1'b1;
                    addr_n  = d_addr_n;
                    state_n = WR_D;
                end
            end
            LINE_END: begin
                a_addr_n = a_addr_q + cur_q.mod_a[ADDR_W-1:0];
                d_addr_n = d_addr_q + cur_q.mod_d[ADDR_W-1:0];
                if (lines_q[15]) begin
                    done_n  = 1'b1;
                    state_n = queued_i ? SETUP : IDLE;
                end else begin
                    state_n = LINE_BEG;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            cur_q   <= '0;
            sel_q   <= 1'b0;
            wr_q    <= 1'b0;
            lines_q <= '0;
            count_q <= '0;
            fmask_q <= '0;
            done_q  <= 1'b0;
        end else if (advance) begin
            state_q <= state_n;
            sel_q   <= sel_n;
            wr_q    <= wr_n;
            lines_q <= lines_n;
            count_q <= count_n;
            fmask_q <= fmask_n;
            done_q  <= done_n;
            if (setup_o) begin
                cur_q <= desc_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            addr_q   <= addr_n;
            a_addr_q <= a_addr_n;
            d_addr_q <= d_addr_n;
        end
    end

    a_req_held: assert property (
        @(posedge clk) disable iff (reset_i)
        (sel_q && !vram_ack_i) |=> (sel_q && $stable(wr_q) && $stable(addr_q))
    ) else $error("vram request changed before ack");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (reset_i) done_q |=> !done_q
    ) else $error("done longer than one cycle");

endmodule

/* source/blitter_top.sv */
module blitter_top import blit_pkg::*; #(
    parameter int ADDR_W = 16           // VRAM address width
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      reg_wr_i,
    input  blit_reg_e reg_num_i,
    input  word_t     reg_data_i,
    output logic      busy_o,
    output logic      full_o,           // descriptor slot taken
    output logic      done_o,
    output vram_req_t vram_req_o,
    input  logic      vram_ack_i,
    input  word_t     vram_data_i,
    output word_t     vram_data_o
);

    blit_desc_t queued_desc;
    logic       setup;
    logic       load_a;
    logic       init_a;
    logic [1:0] shift_amount;
    logic       b_not;
    word_t      val_b;
    word_t      val_c;

    blit_regs regs0 (
        .clk, .reset_i, .reg_wr_i, .reg_num_i, .reg_data_i,
        .setup_i(setup), .desc_o(queued_desc), .queued_o(full_o)
    );

    blit_sequencer #(.ADDR_W(ADDR_W)) seq0 (
        .clk, .reset_i, .desc_i(queued_desc), .queued_i(full_o), .setup_o(setup),
        .vram_ack_i, .vram_req_o, .load_a_o(load_a), .init_a_o(init_a),
        .shift_amount_o(shift_amount), .b_not_o(b_not), .val_b_o(val_b), .val_c_o(val_c),
        .busy_o, .done_o
    );

    blit_datapath dp0 (
        .clk, .reset_i, .vram_ack_i, .vram_data_i, .load_a_i(load_a), .init_a_i(init_a),
        .shift_amount_i(shift_amount), .b_not_i(b_not), .val_b_i(val_b), .val_c_i(val_c),
        .src_a_i(queued_desc.src_a), .data_o(vram_data_o)
    );

endmodule

/* verification/tb_blitter.sv */
module tb_blitter import blit_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W  = 12;        // small VRAM so every word gets compared
    localparam int DEPTH   = 1 << ADDR_W;
    localparam int TIMEOUT = 5000;      // cycles allowed for any single wait
    localparam int NROWS   = 7;

    typedef struct packed {
        blit_desc_t desc;
        word_t      pat;                // VRAM fill before the blit
        logic       queue_next;         // load the next row while this one runs
    } row_t;

    logic      clk;
    logic      reset;
    logic      reg_wr;
    blit_reg_e reg_num;
    word_t     reg_data;
    logic      busy;
    logic      full;
    logic      done;
    vram_req_t vram_req;
    logic      vram_ack;
    word_t     vram_rdata;
    word_t     vram_wdata;
    logic      fill;
    word_t     fill_pat;

    row_t      rows [NROWS];
    word_t     shadow [DEPTH];          // expected VRAM contents
    word_t     ref_last_a;              // previous raw A word, kept across blits
    int        pend_q [$];              // rows started but not yet checked
    int        errors;
    logic      words_seen;

    blitter_top #(.ADDR_W(ADDR_W)) dut0 (
        .clk(clk), .reset_i(reset), .reg_wr_i(reg_wr), .reg_num_i(reg_num),
        .reg_data_i(reg_data), .busy_o(busy), .full_o(full), .done_o(done),
        .vram_req_o(vram_req), .vram_ack_i(vram_ack), .vram_data_i(vram_rdata),
        .vram_data_o(vram_wdata)
    );

    vram_model #(.ADDR_W(ADDR_W)) vram0 (
        .clk(clk), .reset_i(reset), .fill_i(fill), .fill_pat_i(fill_pat),
        .req_i(vram_req), .wdata_i(vram_wdata), .ack_o(vram_ack), .rdata_o(vram_rdata)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        $display("Something failed");
        $fatal(1);
    endtask

    // nothing may touch VRAM before the first blit is queued
    always @(negedge clk) begin
        if (!reset && !words_seen) begin
            check_value("vram select before the first blit", vram_req.sel, 1'b0);
        end
        if (reg_wr && reg_num == BLIT_WORDS) begin
            words_seen = 1'b1;
        end
    end

    task automatic load_table();
        // constant fill, mod_d leaves 4 untouched words between lines
        rows[0] = '{'{1'b1, 1'b0, 2'd0, 4'hf, 4'hf, 16'h0000, 16'h0004, 16'hf0f0,
                      16'h3c3c, 16'h1234, 16'h0100, 16'd2, 16'd3}, 16'h1111, 1'b0};
        // plain copy, NOT 0 passes A through
        rows[1] = '{'{1'b0, 1'b1, 2'd0, 4'hf, 4'hf, 16'h0002, 16'h0005, 16'h0200,
                      16'h0000, 16'h0000, 16'h0300, 16'd3, 16'd5}, 16'h2222, 1'b0};
        rows[2] = '{'{1'b0, 1'b1, 2'd1, 4'h7, 4'he, 16'h0001, 16'h0003, 16'h0400,
                      16'h00ff, 16'h0f0f, 16'h0500, 16'd2, 16'd4}, 16'h3333, 1'b0};
        // rows 3 and 4 run back to back
        rows[3] = '{'{1'b0, 1'b0, 2'd2, 4'h3, 4'hc, 16'h0000, 16'h0002, 16'h0600,
                      16'hffff, 16'h0000, 16'h0680, 16'd3, 16'd3}, 16'h4444, 1'b1};
        rows[4] = '{'{1'b0, 1'b1, 2'd3, 4'h1, 4'h8, 16'h0003, 16'h0001, 16'h0700,
                      16'h0000, 16'ha5a5, 16'h07c0, 16'd4, 16'd2}, 16'h5555, 1'b0};
        // source wraps past the top of VRAM
        rows[5] = '{'{1'b0, 1'b1, 2'd1, 4'hf, 4'hf, 16'h0000, 16'h0000, 16'h0ffc,
                      16'h0000, 16'h0000, 16'h0010, 16'd1, 16'd7}, 16'h6666, 1'b0};
        // one word per line gets f_mask AND l_mask
        rows[6] = '{'{1'b1, 1'b0, 2'd0, 4'h6, 4'h3, 16'h0000, 16'h0007, 16'h5aa5,
                      16'hffff, 16'h0000, 16'h0800, 16'd5, 16'd0}, 16'h7777, 1'b0};
    endtask

    task automatic load_vram(input word_t pat);
        @(posedge clk);
        fill     <= 1'b1;
        fill_pat <= pat;
        @(posedge clk);
        fill     <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = vram0.mem[i];
        end
    endtask

    task automatic write_reg(input blit_reg_e num, input word_t data);
        @(posedge clk);
        reg_wr   <= 1'b1;
        reg_num  <= num;
        reg_data <= data;
    endtask

    task automatic write_blit(input blit_desc_t d);
        write_reg(BLIT_CTRL, {13'd0, d.b_not, 1'b0, d.a_const});
        write_reg(BLIT_SHIFT, {d.f_mask, d.l_mask, 6'd0, d.shift_amount});
        write_reg(BLIT_MOD_A, d.mod_a);
        write_reg(BLIT_MOD_D, d.mod_d);
        write_reg(BLIT_SRC_A, d.src_a);
        write_reg(BLIT_VAL_B, d.val_b);
        write_reg(BLIT_VAL_C, d.val_c);
        write_reg(BLIT_DST_D, d.dst_d);
        write_reg(BLIT_LINES, d.lines);
        write_reg(blit_reg_e'(4'd12), 16'hdead);    // unused number, must be ignored
        write_reg(BLIT_WORDS, d.words);
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic wait_full_low();
        logic free;
        free = 1'b0;
        for (int n = 0; n < TIMEOUT && !free; n++) begin
            @(negedge clk);
            free = !full;
        end
        if (!free) begin
            fail_timeout("the queue slot never became free");
        end
    endtask

    task automatic wait_done();
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            fail_timeout("no done pulse from the blitter");
        end
    endtask

    // expected result of one blit on the shadow VRAM, word by word
    task automatic model_blit(input blit_desc_t d);
        logic [ADDR_W-1:0] a_addr;
        logic [ADDR_W-1:0] d_addr;
        word_t             val_a;
        word_t             raw;
        word_t             b_val;
        word_t             result;
        nib_mask_t         mask;
        a_addr = d.src_a[ADDR_W-1:0];
        d_addr = d.dst_d[ADDR_W-1:0];
        val_a  = d.src_a;
        b_val  = d.b_not ? ~d.val_b : d.val_b;
        for (int line = 0; line <= int'(d.lines); line++) begin
            for (int w = 0; w <= int'(d.words); w++) begin
                if (!d.a_const) begin
                    raw        = shadow[a_addr];
                    val_a      = word_t'({ref_last_a, raw} >> (4 * d.shift_amount));
                    ref_last_a = raw;
                    a_addr++;
                end
                mask = 4'hf;
                if (w == 0) begin
                    mask = mask & d.f_mask;
                end
                if (w == int'(d.words)) begin
                    mask = mask & d.l_mask;
                end
                result = (val_a & b_val) ^ d.val_c;
                for (int n = 0; n < 4; n++) begin
                    if (mask[n]) begin
                        shadow[d_addr][4*n +: 4] = result[4*n +: 4];
                    end
                end
                d_addr++;
            end
            a_addr += d.mod_a[ADDR_W-1:0];
            d_addr += d.mod_d[ADDR_W-1:0];
        end
    endtask

    task automatic compare_vram();
        for (int i = 0; i < DEPTH; i++) begin
            check_value($sformatf("vram word %h", i), vram0.mem[i], shadow[i]);
        end
    endtask

    initial begin
        int idx;
        reset      = 1'b1;
        reg_wr     = 1'b0;
        reg_num    = BLIT_CTRL;
        reg_data   = '0;
        fill       = 1'b0;
        fill_pat   = '0;
        ref_last_a = '0;
        errors     = 0;
        words_seen = 1'b0;
        load_table();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("busy after reset", busy, 1'b0);
        check_value("full after reset", full, 1'b0);
        check_value("done after reset", done, 1'b0);

        for (int r = 0; r < NROWS; r++) begin
            wait_full_low();
            if (pend_q.size() == 0) begin
                load_vram(rows[r].pat);     // a queued row shares the VRAM state
            end
            write_blit(rows[r].desc);
            @(negedge clk);
            check_value("full after queueing a blit", full, 1'b1);
            if (pend_q.size() > 0) begin
                check_value("busy while the next blit is loaded", busy, 1'b1);
            end
            pend_q.push_back(r);
            if (!rows[r].queue_next) begin
                while (pend_q.size() > 0) begin
                    wait_done();
                    idx = pend_q.pop_front();
                    model_blit(rows[idx].desc);
                    compare_vram();
                    check_value("busy at done", busy, pend_q.size() > 0);
                end
            end
        end

        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verification/vram_model.sv */
module vram_model import blit_pkg::*; #(
    parameter int ADDR_W = 16
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      fill_i,           // load the fill pattern into every word
    input  word_t     fill_pat_i,
    input  vram_req_t req_i,
    input  word_t     wdata_i,
    output logic      ack_o,
    output word_t     rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 1 << ADDR_W;

    word_t      mem [DEPTH];
    logic [1:0] wait_q;                 // cycles the current request has waited
    logic [1:0] delay_q;                // ack delay for the current request
    integer     seed = 32'h6b9329b4;

    function automatic word_t fill_word(input int addr, input word_t pat);
        return word_t'(addr * 32'h9e37) ^ word_t'(addr >> 5) ^ pat;
    endfunction

    function automatic word_t expand_mask(input nib_mask_t m);
        return {{4{m[3]}}, {4{m[2]}}, {4{m[1]}}, {4{m[0]}}};
    endfunction

    assign ack_o   = req_i.sel && (wait_q == delay_q);
    assign rdata_o = mem[req_i.addr[ADDR_W-1:0]];  // valid in the ack cycle

    always @(posedge clk) begin
        if (reset_i) begin
            wait_q  <= '0;
            delay_q <= '0;
        end else begin
            if (fill_i) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= fill_word(i, fill_pat_i);
                end
            end
            if (ack_o) begin
                wait_q  <= '0;
                delay_q <= 2'($random(seed));   // 0 to 3 cycles for the next one
                if (req_i.wr) begin
                    mem[req_i.addr[ADDR_W-1:0]] <=
                        (mem[req_i.addr[ADDR_W-1:0]] & ~expand_mask(req_i.wr_mask)) |
                        (wdata_i & expand_mask(req_i.wr_mask));
                end
            end else if (req_i.sel) begin
                wait_q <= wait_q + 2'd1;
            end
        end
    end

endmodule
